// ==== source/csr_pkg.sv ====
// Package with CSR widths, address table, operation codes, address union and exception codes.
`default_nettype none

package csr_pkg;

  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;
  localparam int reg_idx_w  = 5;

  // Same 12-bit address seen whole for table lookup, or split into its encoded fields.
  typedef union packed {
    logic [csr_addr_w-1:0] raw;
    struct packed {
      logic [1:0] access;  // 2'b11 marks a read-only CSR.
      logic [1:0] priv;    // Lowest privilege allowed to access.
      logic [7:0] index;
    } fields;
  } csr_addr_u;

  // Values match func3[1:0] of the CSR instructions.
  typedef enum logic [1:0] {
    op_write = 2'b01,
    op_set   = 2'b10,
    op_clear = 2'b11
  } csr_op_e;

  // Writable machine registers.
  localparam logic [csr_addr_w-1:0] csr_mtvec    = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mtval    = 12'h343;

  // Read-only identity registers.
  localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hF11;
  localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hF12;
  localparam logic [csr_addr_w-1:0] csr_mimpid    = 12'hF13;
  localparam logic [csr_addr_w-1:0] csr_mhartid   = 12'hF14;

  localparam logic [1:0] csr_acc_rdonly = 2'b11;

  localparam logic [6:0] opcode_system = 7'b1110011;

  localparam logic [1:0] priv_machine = 2'b11;

  // Exception code reported for every CSR violation.
  localparam logic [4:0] expt_illegal_inst = 5'd2;

endpackage

`default_nettype wire

// ==== source/csr_req_if.sv ====
// Interface carrying one decoded CSR request, with decoder, check and file views.
`timescale 1ns/1ps
`default_nettype none

interface csr_req_if
  import csr_pkg::*;
();

  logic            valid;      // CSR instruction selected this cycle.
  csr_op_e         op;
  logic [xlen-1:0] operand;    // rs1 data or zero-extended uimm.
  csr_addr_u       addr;
  logic            wr_intent;  // Instruction would modify the CSR.
  logic            rd_x0;

  modport decoder (output valid, op, operand, addr, wr_intent, rd_x0);

  // Access check sees only the address and the write intent.
  modport check (input valid, addr, wr_intent);

  modport file (input valid, op, operand, addr, wr_intent);

endinterface

`default_nettype wire

// ==== source/csr_decode.sv ====
// CSR instruction decoder producing the request and the rebuilt instruction word.
`timescale 1ns/1ps
`default_nettype none

module csr_decode
  import csr_pkg::*;
(
  input  logic                 sel,
  input  logic [2:0]           func3,
  input  logic [reg_idx_w-1:0] rd_reg,
  input  logic [reg_idx_w-1:0] rs1_reg,
  input  csr_addr_u            csr_addr,
  input  logic [xlen-1:0]      rs1_data,
  csr_req_if.decoder           req,
  output logic [xlen-1:0]      tval
);

  logic    imm_sel;
  logic    rs1_zero;
  csr_op_e op;

  assign imm_sel  = func3[2];
  assign rs1_zero = (rs1_reg == '0);

  // func3 of 0 and 4 are not CSR instructions.
  always_comb
  begin
    case (func3[1:0])
      2'b10:   op = op_set;
      2'b11:   op = op_clear;
      default: op = op_write;
    endcase
  end

  assign req.valid = sel && (func3[1:0] != 2'b00);
  assign req.op    = op;
  assign req.addr  = csr_addr;
  assign req.rd_x0 = (rd_reg == '0);

  // In the immediate forms the rs1 field is the uimm itself.
  assign req.operand = imm_sel ? {{(xlen - reg_idx_w){1'b0}}, rs1_reg} : rs1_data;

  // Set and clear with a zero source field only read.
  assign req.wr_intent = (op == op_write) || !rs1_zero;

  // Faulting instruction, reported as the exception value.
  assign tval = {csr_addr.raw, rs1_reg, func3, rd_reg, opcode_system};

endmodule

`default_nettype wire

// ==== source/csr_access_check.sv ====
// CSR access check: address table lookup, privilege rule and read-only write rule.
`timescale 1ns/1ps
`default_nettype none

module csr_access_check
  import csr_pkg::*;
(
  csr_req_if.check   req,
  input  logic [1:0] priv_mode,
  output logic       expt
);

  logic addr_known;
  logic priv_low;
  logic wr_rdonly;

  always_comb
  begin
    case (req.addr.raw)
      csr_mtvec,
      csr_mscratch,
      csr_mepc,
      csr_mcause,
      csr_mtval,
      csr_mvendorid,
      csr_marchid,
      csr_mimpid,
      csr_mhartid: addr_known = 1'b1;
      default:     addr_known = 1'b0;
    endcase
  end

  // Only machine mode may touch any of these CSRs.
  assign priv_low = (priv_mode < priv_machine);

  // Read-only space is recognized from the address encoding alone.
  assign wr_rdonly = req.wr_intent && (req.addr.fields.access == csr_acc_rdonly);

  assign expt = req.valid && (!addr_known || priv_low || wr_rdonly);

endmodule

`default_nettype wire

// ==== source/csr_file.sv ====
// CSR file: writable machine registers, identity values, read mux and write-value logic.
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] vendor_id = '0,
  parameter logic [xlen-1:0] arch_id   = '0,
  parameter logic [xlen-1:0] impl_id   = '0,
  parameter logic [xlen-1:0] hart_id   = '0
)
(
  input  logic            clk,
  input  logic            rst_n,
  csr_req_if.file         req,
  input  logic            expt,
  output logic [xlen-1:0] rdata
);

  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;

  logic [xlen-1:0] wdata;
  logic            wr_en;

  // Old value, also the base for set and clear.
  always_comb
  begin
    case (req.addr.raw)
      csr_mtvec:     rdata = mtvec_q;
      csr_mscratch:  rdata = mscratch_q;
      csr_mepc:      rdata = mepc_q;
      csr_mcause:    rdata = mcause_q;
      csr_mtval:     rdata = mtval_q;
      csr_mvendorid: rdata = vendor_id;
      csr_marchid:   rdata = arch_id;
      csr_mimpid:    rdata = impl_id;
      csr_mhartid:   rdata = hart_id;
      default:       rdata = '0;
    endcase
  end

  always_comb
  begin
    case (req.op)
      op_set:   wdata = rdata | req.operand;
      op_clear: wdata = rdata & ~req.operand;
      default:  wdata = req.operand;
    endcase
  end

  // A faulting access leaves every register untouched.
  assign wr_en = req.valid && req.wr_intent && !expt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end
    else if (wr_en)
    begin
      case (req.addr.raw)
        csr_mtvec:    mtvec_q    <= wdata;
        csr_mscratch: mscratch_q <= wdata;
        csr_mepc:     mepc_q     <= wdata;
        csr_mcause:   mcause_q   <= wdata;
        csr_mtval:    mtval_q    <= wdata;
        default:      ;  // Identity CSRs never reach here.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/csr_unit_top.sv ====
// CSR unit top level: decoder, access check and CSR file, with result and exception outputs.
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] vendor_id = '0,
  parameter logic [xlen-1:0] arch_id   = '0,
  parameter logic [xlen-1:0] impl_id   = '0,
  parameter logic [xlen-1:0] hart_id   = '0
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_sel,
  input  logic [2:0]            func3,
  input  logic [reg_idx_w-1:0]  rd_reg,
  input  logic [reg_idx_w-1:0]  rs1_reg,
  input  logic [csr_addr_w-1:0] csr_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [1:0]            priv_mode,
  output logic [xlen-1:0]       data,
  output logic                  data_vld,
  output logic                  expt_vld,
  output logic [4:0]            expt_vec,
  output logic [xlen-1:0]       tval,
  output logic                  flush,
  output logic                  req
);

  logic            expt;
  logic [xlen-1:0] rdata;
  logic            op_sc;

  csr_req_if csr_req ();

  csr_decode i_csr_decode (
    .sel      (ex_sel),
    .func3    (func3),
    .rd_reg   (rd_reg),
    .rs1_reg  (rs1_reg),
    .csr_addr (csr_addr),
    .rs1_data (rs1_data),
    .req      (csr_req.decoder),
    .tval     (tval)
  );

  csr_access_check i_csr_access_check (
    .req       (csr_req.check),
    .priv_mode (priv_mode),
    .expt      (expt)
  );

  csr_file #(
    .vendor_id (vendor_id),
    .arch_id   (arch_id),
    .impl_id   (impl_id),
    .hart_id   (hart_id)
  ) i_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (csr_req.file),
    .expt  (expt),
    .rdata (rdata)
  );

  assign op_sc = (csr_req.op != op_write);

  // Set and clear report a result even to x0.
  assign data_vld = csr_req.valid && (!csr_req.rd_x0 || op_sc) && !expt;
  assign data     = rdata;

  assign expt_vld = expt;
  assign expt_vec = expt_illegal_inst;

  assign flush = csr_req.valid;  // Every CSR instruction refetches.
  assign req   = ex_sel;

endmodule

`default_nettype wire

// ==== bench/csr_unit_assert.sv ====
// Concurrent assertions on the CSR unit outputs and their bind to the top level.
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assert
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       ex_sel,
  input  wire logic       data_vld,
  input  wire logic       expt_vld,
  input  wire logic [4:0] expt_vec,
  input  wire logic       flush
);

  int fail_count;

  // A faulting instruction never writes back a result.
  expt_blocks_data: assert property (@(posedge clk) disable iff (!rst_n)
    expt_vld |-> !data_vld)
  else
  begin
    $error("data_vld high together with expt_vld");
    fail_count++;
  end

  expt_code_illegal: assert property (@(posedge clk) disable iff (!rst_n)
    expt_vld |-> (expt_vec == 5'd2))
  else
  begin
    $error("expt_vec is not the illegal-instruction code");
    fail_count++;
  end

  flush_needs_sel: assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> ex_sel)
  else
  begin
    $error("flush raised while ex_sel is low");
    fail_count++;
  end

endmodule

bind csr_unit_top csr_unit_assert i_csr_unit_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .ex_sel   (ex_sel),
  .data_vld (data_vld),
  .expt_vld (expt_vld),
  .expt_vec (expt_vec),
  .flush    (flush)
);

`default_nettype wire

// ==== bench/csr_unit_tb.sv ====
// Testbench for the CSR unit: clock, reset, vector reader, output checks and watchdog.
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

  localparam real   clk_period = 4.0;
  localparam int    max_vec    = 256;
  localparam string stim_path  = "bench/csr_stimulus.txt";

  logic        clk;
  logic        rst_n;
  logic        ex_sel;
  logic [2:0]  func3;
  logic [4:0]  rd_reg;
  logic [4:0]  rs1_reg;
  logic [11:0] csr_addr;
  logic [31:0] rs1_data;
  logic [1:0]  priv_mode;
  logic [31:0] data;
  logic        data_vld;
  logic        expt_vld;
  logic [4:0]  expt_vec;
  logic [31:0] tval;
  logic        flush;
  logic        req;

  // One entry per stimulus line, inputs then expected outputs.
  logic [31:0] vec_in  [0:max_vec-1][0:6];
  logic [31:0] vec_exp [0:max_vec-1][0:3];

  int   num_vec;
  int   value_errors;
  int   other_errors;
  int   assert_errors;
  logic loaded;

  csr_unit_top #(
    .vendor_id (32'h0000_0000),
    .arch_id   (32'h0000_0000),
    .impl_id   (32'h0000_0001),
    .hart_id   (32'h0000_0000)
  ) i_csr_unit_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_sel    (ex_sel),
    .func3     (func3),
    .rd_reg    (rd_reg),
    .rs1_reg   (rs1_reg),
    .csr_addr  (csr_addr),
    .rs1_data  (rs1_data),
    .priv_mode (priv_mode),
    .data      (data),
    .data_vld  (data_vld),
    .expt_vld  (expt_vld),
    .expt_vec  (expt_vec),
    .tval      (tval),
    .flush     (flush),
    .req       (req)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic load_vectors;
    int          fd;
    int          n;
    int          line_no;
    string       line;
    logic [31:0] f [0:10];
    line_no = 0;
    fd = $fopen(stim_path, "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file %s", stim_path);
      other_errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        line_no++;
        if (line.len() > 1 && line[0] != "#")  // Skip comments and blank lines.
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
          if (n != 11)
          begin
            $display("Stimulus line %0d does not hold eleven fields and was skipped", line_no);
            other_errors++;
          end
          else if (num_vec >= max_vec)
          begin
            $display("Stimulus line %0d is beyond the vector storage and was skipped", line_no);
            other_errors++;
          end
          else
          begin
            for (int k = 0; k < 7; k++)
              vec_in[num_vec][k] = f[k];
            for (int k = 0; k < 4; k++)
              vec_exp[num_vec][k] = f[k + 7];
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // RISC-V I-type SYSTEM instruction word of a CSR access.
  function automatic logic [31:0] system_inst(input logic [11:0] addr, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    logic [31:0] word;
    word        = 32'h0000_0073;
    word[31:20] = addr;
    word[19:15] = rs1;
    word[14:12] = f3;
    word[11:7]  = rd;
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val, input int idx);
    if (act_val !== exp_val)
    begin
      $display("FAIL %s at vector %0d: expected %h, got %h", name, idx, exp_val, act_val);
      value_errors++;
    end
  endtask

  initial
  begin
    rst_n         = 1'b0;
    ex_sel        = 1'b0;
    func3         = '0;
    rd_reg        = '0;
    rs1_reg       = '0;
    csr_addr      = '0;
    rs1_data      = '0;
    priv_mode     = 2'b11;
    num_vec       = 0;
    value_errors  = 0;
    other_errors  = 0;
    assert_errors = 0;
    loaded        = 1'b0;

    load_vectors();
    if (num_vec == 0)
    begin
      $display("No stimulus vectors were read, nothing was tested");
      other_errors++;
    end
    loaded = 1'b1;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < num_vec; i++)
    begin
      @(posedge clk);
      ex_sel    <= vec_in[i][0][0];
      func3     <= vec_in[i][1][2:0];
      rd_reg    <= vec_in[i][2][4:0];
      rs1_reg   <= vec_in[i][3][4:0];
      csr_addr  <= vec_in[i][4][11:0];
      rs1_data  <= vec_in[i][5];
      priv_mode <= vec_in[i][6][1:0];
      @(negedge clk);
      #(clk_period / 2 - 0.5);  // Just before the next rising edge.
      if (vec_exp[i][1][0])
        check_value("data", vec_exp[i][0], data, i);
      check_value("data_vld", {31'd0, vec_exp[i][1][0]}, {31'd0, data_vld}, i);
      check_value("expt_vld", {31'd0, vec_exp[i][2][0]}, {31'd0, expt_vld}, i);
      if (vec_exp[i][2][0])
        check_value("expt_vec", 32'd2, {27'd0, expt_vec}, i);  // Illegal instruction.
      check_value("tval",
                  system_inst(vec_in[i][4][11:0], vec_in[i][3][4:0],
                              vec_in[i][1][2:0], vec_in[i][2][4:0]),
                  tval, i);
      check_value("flush", {31'd0, vec_exp[i][3][0]}, {31'd0, flush}, i);
      check_value("req", {31'd0, vec_in[i][0][0]}, {31'd0, req}, i);  // Mirrors ex_sel.
    end

    assert_errors = i_csr_unit_top.i_csr_unit_assert.fail_count;
    $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // Allows every vector plus reset and margin, twice over.
  initial
  begin
    wait (loaded);
    #((num_vec + 10) * clk_period * 2);
    $display("Watchdog expired before the vectors were done");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/csr_pkg.sv
source/csr_req_if.sv
source/csr_decode.sv
source/csr_access_check.sv
source/csr_file.sv
source/csr_unit_top.sv
bench/csr_unit_assert.sv
bench/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - source/csr_pkg.sv
  - source/csr_req_if.sv
  - source/csr_decode.sv
  - source/csr_access_check.sv
  - source/csr_file.sv
  - source/csr_unit_top.sv
  - target: test
    files:
      - bench/csr_unit_assert.sv
      - bench/csr_unit_tb.sv

// ==== bench/csr_stimulus.txt ====
# Columns in hex: ex_sel func3 rd_reg rs1_reg csr_addr rs1_data priv_mode
# then expected: data data_vld expt_vld flush (data is checked only when data_vld is 1)
# Reset values and identity registers, read with CSRRS and rs1 of zero
1 2 01 00 340 00000000 3 00000000 1 0 1
1 2 01 00 341 00000000 3 00000000 1 0 1
1 2 01 00 342 00000000 3 00000000 1 0 1
1 2 01 00 343 00000000 3 00000000 1 0 1
1 2 01 00 305 00000000 3 00000000 1 0 1
1 2 01 00 F11 00000000 3 00000000 1 0 1
1 2 01 00 F12 00000000 3 00000000 1 0 1
1 2 01 00 F13 00000000 3 00000001 1 0 1
1 2 01 00 F14 00000000 3 00000000 1 0 1
# Read-modify-write on mscratch
1 1 01 05 340 A5A50000 3 00000000 1 0 1
1 2 01 05 340 000000FF 3 A5A50000 1 0 1
1 3 01 05 340 A5000000 3 A5A500FF 1 0 1
1 2 01 00 340 00000000 3 00A500FF 1 0 1
# Immediate forms on mepc, rs1_data must be ignored
1 5 02 13 341 FFFFFFFF 3 00000000 1 0 1
1 6 02 04 341 FFFFFFFF 3 00000013 1 0 1
1 7 02 01 341 FFFFFFFF 3 00000017 1 0 1
1 2 02 00 341 00000000 3 00000016 1 0 1
# Zero source field writes nothing, also on a read-only address
1 2 03 00 F14 FFFFFFFF 3 00000000 1 0 1
1 3 03 00 340 FFFFFFFF 3 00A500FF 1 0 1
1 2 03 00 340 00000000 3 00A500FF 1 0 1
# Destination x0, CSRRW hides the result but still writes, set still reports
1 1 00 06 343 12345678 3 00000000 0 0 1
1 2 04 00 343 00000000 3 12345678 1 0 1
1 2 00 07 343 0000000F 3 12345678 1 0 1
1 2 04 00 343 00000000 3 1234567F 1 0 1
# Exceptions, each followed by a read-back
1 1 01 08 F11 DEADBEEF 3 00000000 0 1 1
1 2 01 00 F11 00000000 3 00000000 1 0 1
1 2 01 00 7C0 00000000 3 00000000 0 1 1
1 1 01 09 7C0 11111111 3 00000000 0 1 1
1 1 01 0A 340 DEADBEEF 0 00000000 0 1 1
1 2 01 00 340 00000000 3 00A500FF 1 0 1
# Remaining writable registers
1 5 01 1F 342 00000000 3 00000000 1 0 1
1 1 01 0B 305 80000100 3 00000000 1 0 1
1 2 01 00 342 00000000 3 0000001F 1 0 1
1 2 01 00 305 00000000 3 80000100 1 0 1
# Idle and a non-CSR func3, neither may write
0 1 01 05 340 FFFFFFFF 3 00000000 0 0 0
1 0 01 05 340 FFFFFFFF 3 00000000 0 0 0
1 2 01 00 340 00000000 3 00A500FF 1 0 1
0 0 00 00 000 00000000 0 00000000 0 0 0
